// File: Bender.yml
package:
  name: stats_unit

export_include_dirs:
  - hw

sources:
  - target: rtl
    include_dirs:
      - hw
    files:
      - hw/stats_data_pkg.sv
      - hw/stats_cmd_pkg.sv
      - hw/stats_extreme.sv
      - hw/stats_accum.sv
      - hw/stats_ctrl.sv
      - hw/stats_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/stats_tb.sv

// File: hw/stats_accum.sv
`timescale 1ns/1ps
`default_nettype none

`include "stats_cfg.svh"

module stats_accum
  import stats_data_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        clr,
  input  logic                        en,
  input  sample_t                     val,
  output logic [`STATS_SUM_WIDTH-1:0] sum,
  output logic [`STATS_CNT_WIDTH-1:0] count,
  output logic                        overflow
);

  // One extra bit on each adder catches the carry out.
  logic [`STATS_SUM_WIDTH:0] sum_nxt;
  logic [`STATS_CNT_WIDTH:0] count_nxt;

  assign sum_nxt   = (`STATS_SUM_WIDTH + 1)'(sum) + (`STATS_SUM_WIDTH + 1)'(val);
  assign count_nxt = (`STATS_CNT_WIDTH + 1)'(count) + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n || clr) begin
      sum      <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else if (en) begin
      sum   <= sum_nxt[`STATS_SUM_WIDTH-1:0];
      count <= count_nxt[`STATS_CNT_WIDTH-1:0];
      if (sum_nxt[`STATS_SUM_WIDTH] || count_nxt[`STATS_CNT_WIDTH]) begin
        overflow <= 1'b1;  // Stays set until the next clear.
      end
    end
  end

  a_count_cause: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(count) |-> ($past(en) || $past(clr)));

endmodule

`default_nettype wire

// File: hw/stats_cfg.svh
`ifndef STATS_CFG_SVH
`define STATS_CFG_SVH

// Width of one unsigned input sample.
`define STATS_WIDTH 8

// Output registers behind each running-extreme tracker.
`define STATS_STAGES 2

// The sum and count wrap and flag overflow.
`define STATS_SUM_WIDTH 16
`define STATS_CNT_WIDTH 8

`endif

// File: hw/stats_cmd_pkg.sv
`default_nettype none

package stats_cmd_pkg;

  typedef enum logic [1:0] {
    OP_CLEAR    = 2'd0,
    OP_START    = 2'd1,
    OP_STOP     = 2'd2,
    OP_SNAPSHOT = 2'd3
  } stats_op_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DRAIN = 2'd2
  } ctrl_state_e;

  typedef struct packed {
    logic      valid;
    stats_op_e op;
  } stats_cmd_t;

endpackage

`default_nettype wire

// File: hw/stats_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "stats_cfg.svh"

module stats_ctrl
  import stats_data_pkg::*;
  import stats_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  stats_cmd_t cmd,
  input  logic       sample_en,
  input  stats_t     stats,
  output logic       acc_en,
  output logic       clr,
  output logic       busy,
  output logic       report_valid,
  output report_t    report
);

  localparam int DRAIN_W = $clog2(`STATS_STAGES + 2);
  localparam logic [`STATS_CNT_WIDTH-1:0] DROP_MAX = '1;

  ctrl_state_e                 state;
  ctrl_state_e                 ret_state;
  stats_cmd_t                  cmd_q;
  logic [DRAIN_W-1:0]          drain_cnt;
  logic [`STATS_CNT_WIDTH-1:0] dropped;
  logic                        cmd_live;
  logic                        drain_done;

  // Commands that land while draining are simply lost.
  assign cmd_live   = cmd_q.valid && (state != ST_DRAIN);
  assign drain_done = (state == ST_DRAIN) && (drain_cnt == DRAIN_W'(`STATS_STAGES));

  assign acc_en = sample_en && (state == ST_RUN);
  assign busy   = (state == ST_DRAIN);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_q <= '0;
    end else begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      ret_state <= ST_IDLE;
      drain_cnt <= '0;
    end else begin
      case (state)
        ST_DRAIN: begin
          if (drain_done) begin
            state <= ret_state;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        default: begin
          if (cmd_live) begin
            case (cmd_q.op)
              OP_START: state <= ST_RUN;
              OP_STOP:  state <= ST_IDLE;
              OP_SNAPSHOT: begin
                ret_state <= state;  // Come back here once the report is out.
                drain_cnt <= '0;
                state     <= ST_DRAIN;
              end
              default: ;  // OP_CLEAR only raises clr below.
            endcase
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clr          <= 1'b0;
      report_valid <= 1'b0;
      dropped      <= '0;
    end else begin
      clr          <= cmd_live && (cmd_q.op == OP_CLEAR);
      report_valid <= drain_done;
      if (clr) begin
        dropped <= '0;
      end else if (sample_en && !acc_en && (dropped != DROP_MAX)) begin
        dropped <= dropped + 1'b1;
      end
    end
  end

  // The extreme pipelines have settled by the time the drain count expires.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      report <= '0;
    end else if (drain_done) begin
      report.stats   <= stats;
      report.dropped <= dropped;
    end
  end

  a_report_single: assert property (@(posedge clk) disable iff (!rst_n)
    report_valid |=> !report_valid);

endmodule

`default_nettype wire

// File: hw/stats_data_pkg.sv
`default_nettype none

`include "stats_cfg.svh"

package stats_data_pkg;

  typedef logic [`STATS_WIDTH-1:0] sample_t;

  // Live statistics as they leave the datapath.
  typedef struct packed {
    sample_t                      min;
    sample_t                      max;
    logic [`STATS_SUM_WIDTH-1:0]  sum;
    logic [`STATS_CNT_WIDTH-1:0]  count;
    logic                         overflow;  // Sticky, sum or count wrapped.
  } stats_t;

  // One snapshot as delivered to the consumer.
  typedef struct packed {
    stats_t                      stats;
    logic [`STATS_CNT_WIDTH-1:0] dropped;  // Saturates at all ones.
  } report_t;

endpackage

`default_nettype wire

// File: hw/stats_extreme.sv
`timescale 1ns/1ps
`default_nettype none

`include "stats_cfg.svh"

module stats_extreme
  import stats_data_pkg::*;
#(
  parameter int FIND_MAX = 0,
  parameter int STAGES   = `STATS_STAGES
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    clr,
  input  logic    en,
  input  sample_t val,
  output sample_t result
);

  // A minimum starts high and a maximum starts low.
  localparam sample_t INIT = (FIND_MAX != 0) ? sample_t'(0) : ~sample_t'(0);

  // Entry 0 tracks the extreme, the rest only delay it.
  sample_t stage_q [STAGES+1];
  logic    beats;

  assign beats  = (FIND_MAX != 0) ? (val > stage_q[0]) : (val < stage_q[0]);
  assign result = stage_q[STAGES];

  always_ff @(posedge clk) begin
    if (!rst_n || clr) begin
      for (int i = 0; i <= STAGES; i++) begin
        stage_q[i] <= INIT;
      end
    end else begin
      if (en && beats) begin
        stage_q[0] <= val;
      end
      for (int i = 1; i <= STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  if (FIND_MAX == 0) begin : g_min_check
    // Through the whole pipe a minimum can only fall.
    a_min_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
      !clr |=> (result <= $past(result)));
  end

endmodule

`default_nettype wire

// File: hw/stats_top.sv
`timescale 1ns/1ps
`default_nettype none

module stats_top
  import stats_data_pkg::*;
  import stats_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  stats_cmd_t cmd,
  input  logic       sample_en,
  input  sample_t    sample,
  output logic       busy,
  output logic       report_valid,
  output report_t    report
);

  logic   acc_en;
  logic   clr;
  stats_t stats;  // Each datapath block drives its own fields.

  stats_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .sample_en   (sample_en),
    .stats       (stats),
    .acc_en      (acc_en),
    .clr         (clr),
    .busy        (busy),
    .report_valid(report_valid),
    .report      (report)
  );

  stats_extreme #(
    .FIND_MAX(0)
  ) min_i (
    .clk   (clk),
    .rst_n (rst_n),
    .clr   (clr),
    .en    (acc_en),
    .val   (sample),
    .result(stats.min)
  );

  stats_extreme #(
    .FIND_MAX(1)
  ) max_i (
    .clk   (clk),
    .rst_n (rst_n),
    .clr   (clr),
    .en    (acc_en),
    .val   (sample),
    .result(stats.max)
  );

  stats_accum accum_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clr     (clr),
    .en      (acc_en),
    .val     (sample),
    .sum     (stats.sum),
    .count   (stats.count),
    .overflow(stats.overflow)
  );

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/stats_data_pkg.sv
hw/stats_cmd_pkg.sv
hw/stats_extreme.sv
hw/stats_accum.sv
hw/stats_ctrl.sv
hw/stats_top.sv
tests/stats_tb.sv

// File: tests/stats_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "stats_cfg.svh"

module stats_tb
  import stats_data_pkg::*;
  import stats_cmd_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int REPORT_LAT  = `STATS_STAGES + 2;
  localparam int STREAM_LEN  = 300;
  localparam int SNAP_CYCLES = REPORT_LAT + 3;
  // Reset, eight snapshots, five commands, the long stream and the short directed runs.
  localparam int RUN_CYCLES  = 3 + 8 * SNAP_CYCLES + 5 * 3 + STREAM_LEN + 20;
  localparam int TIMEOUT_NS  = (RUN_CYCLES + 100) * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  stats_cmd_t cmd;
  logic       sample_en;
  sample_t    sample;
  logic       busy;
  logic       report_valid;
  report_t    report;

  report_t     model;        // Expected report, kept up to date as stimulus goes out.
  logic        model_run;
  logic        sum_wrapped;
  logic        cnt_wrapped;
  logic [31:0] lcg_state;

  stats_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .sample_en   (sample_en),
    .sample      (sample),
    .busy        (busy),
    .report_valid(report_valid),
    .report      (report)
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic sample_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return sample_t'(lcg_state >> 16);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic field_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s is 0x%0h, expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    field_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic compare_report(input report_t got, input report_t exp);
    field_mismatch("report.stats.min", 32'(got.stats.min), 32'(exp.stats.min));
    field_mismatch("report.stats.max", 32'(got.stats.max), 32'(exp.stats.max));
    field_mismatch("report.stats.sum", 32'(got.stats.sum), 32'(exp.stats.sum));
    field_mismatch("report.stats.count", 32'(got.stats.count), 32'(exp.stats.count));
    field_mismatch("report.stats.overflow", 32'(got.stats.overflow),
                   32'(exp.stats.overflow));
    field_mismatch("report.dropped", 32'(got.dropped), 32'(exp.dropped));
  endtask

  task automatic reset_model();
    model.stats.min      = '1;
    model.stats.max      = '0;
    model.stats.sum      = '0;
    model.stats.count    = '0;
    model.stats.overflow = 1'b0;
    model.dropped        = '0;
    sum_wrapped          = 1'b0;
    cnt_wrapped          = 1'b0;
  endtask

  task automatic accept_sample(input sample_t v);
    logic [`STATS_SUM_WIDTH:0] sum_ext;
    logic [`STATS_CNT_WIDTH:0] cnt_ext;
    if (v < model.stats.min) model.stats.min = v;
    if (v > model.stats.max) model.stats.max = v;
    sum_ext = {1'b0, model.stats.sum} + v;
    cnt_ext = {1'b0, model.stats.count} + 1'b1;
    if (sum_ext[`STATS_SUM_WIDTH]) sum_wrapped = 1'b1;
    if (cnt_ext[`STATS_CNT_WIDTH]) cnt_wrapped = 1'b1;
    model.stats.sum      = sum_ext[`STATS_SUM_WIDTH-1:0];
    model.stats.count    = cnt_ext[`STATS_CNT_WIDTH-1:0];
    model.stats.overflow = model.stats.overflow | sum_wrapped | cnt_wrapped;
  endtask

  task automatic count_drop();
    if (model.dropped != '1) model.dropped = model.dropped + 1'b1;  // Saturates.
  endtask

  task automatic push_sample(input sample_t v);
    @(posedge clk);
    sample_en <= 1'b1;
    sample    <= v;
    if (model_run) begin
      accept_sample(v);
    end else begin
      count_drop();
    end
  endtask

  task automatic release_sample();
    @(posedge clk);
    sample_en <= 1'b0;
  endtask

  // Returns one edge after the command is registered, when it has taken effect.
  task automatic send_cmd(input stats_op_e op);
    @(posedge clk);
    cmd.valid <= 1'b1;
    cmd.op    <= op;
    @(posedge clk);
    cmd <= '0;
    @(posedge clk);
    case (op)
      OP_START: model_run = 1'b1;
      OP_STOP:  model_run = 1'b0;
      OP_CLEAR: reset_model();
      default: ;
    endcase
  endtask

  // Up to STAGES samples can be sent during the drain and still show in dropped.
  task automatic take_snapshot(input int n_drain);
    @(posedge clk);
    cmd.valid <= 1'b1;
    cmd.op    <= OP_SNAPSHOT;
    @(posedge clk);
    cmd <= '0;
    for (int k = 1; k <= REPORT_LAT + 1; k++) begin
      @(posedge clk);
      if (k <= n_drain) begin
        sample_en <= 1'b1;
        sample    <= next_rand();
        count_drop();
      end else begin
        sample_en <= 1'b0;
      end
      @(negedge clk);
      if (k < REPORT_LAT) begin
        if (report_valid === 1'b1) begin
          abort_run($sformatf("report_valid rose %0d cycles after the snapshot command, expected %0d.",
                              k, REPORT_LAT));
        end
        compare_bit("busy", busy, 1'b1);
      end else if (k == REPORT_LAT) begin
        if (report_valid !== 1'b1) begin
          abort_run($sformatf("report_valid did not rise %0d cycles after the snapshot command.",
                              REPORT_LAT));
        end
        compare_bit("busy", busy, 1'b0);
        compare_report(report, model);
      end else begin
        compare_bit("report_valid", report_valid, 1'b0);
        compare_report(report, model);  // Held after the pulse.
      end
    end
  endtask

  task automatic check_after_reset();
    report_t cleared;
    cleared = '0;
    @(negedge clk);
    compare_bit("busy", busy, 1'b0);
    compare_bit("report_valid", report_valid, 1'b0);
    compare_report(report, cleared);
    take_snapshot(0);
  endtask

  task automatic run_directed_stream();
    send_cmd(OP_START);
    @(negedge clk);
    compare_bit("busy", busy, 1'b0);
    push_sample(8'h42);
    push_sample(8'h20);
    push_sample(8'h30);
    push_sample(8'h00);
    push_sample(8'h90);
    release_sample();
    take_snapshot(0);
  endtask

  task automatic check_dropped_samples();
    take_snapshot(`STATS_STAGES);
    send_cmd(OP_STOP);
    push_sample(8'h05);
    push_sample(8'hf0);
    push_sample(8'h7a);
    release_sample();
    take_snapshot(1);
  endtask

  task automatic check_clear();
    send_cmd(OP_START);
    push_sample(8'h11);
    push_sample(8'hee);
    release_sample();
    send_cmd(OP_CLEAR);
    take_snapshot(0);
    push_sample(8'h55);
    push_sample(8'h33);
    push_sample(8'h77);
    release_sample();
    take_snapshot(0);
  endtask

  task automatic run_overflow_stream();
    sample_t v;
    send_cmd(OP_CLEAR);
    for (int i = 0; i < STREAM_LEN; i++) begin
      if (i == 256) begin
        release_sample();
        take_snapshot(0);  // The count has just wrapped.
      end
      v = next_rand() | sample_t'(8'he0);  // High samples push the sum past its width too.
      push_sample(v);
    end
    release_sample();
    take_snapshot(0);
    if (!(sum_wrapped && cnt_wrapped)) begin
      abort_run("The long stream did not carry out of both the sum and the count.");
    end
  endtask

  initial begin
    lcg_state = 32'd11;
    rst_n     = 1'b0;
    cmd       = '0;
    sample_en = 1'b0;
    sample    = '0;
    model_run = 1'b0;
    reset_model();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    check_after_reset();
    run_directed_stream();
    check_dropped_samples();
    check_clear();
    run_overflow_stream();
    $display("Test passed");
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    abort_run("Watchdog expired before the tests finished.");
  end

endmodule

`default_nettype wire
